// ==== Makefile ====
# Verilator build and run of the VIDC observer testbench
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_vidc_capture \
		-f sim.f -Mdir obj_dir -o vsim

run: compile
	./obj_dir/vsim > $(LOG)
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== rtl/cursor_geometry.sv ====
/*
 * Cursor position for the display logic. The horizontal start is taken
 * at the resolution of the pixel clock mode, and the vertical window is
 * made relative to the start of the displayed area.
 */

`timescale 1ns/1ps
`default_nettype none

module cursor_geometry import vidc_pkg::*; (
   input  wire           conf_hires,
   input  cursor_hpos_t  hcsr,
   input  timing_t       vdsr,
   input  timing_t       vcsr,
   input  timing_t       vcer,
   output cursor_x_t     cursor_hstart,
   output timing_t       cursor_vstart,
   output timing_t       cursor_vend
);

   // Hires pixels are four times finer
   assign cursor_hstart = conf_hires ? hcsr[10:0] : hcsr[12:2];

   // Wraps at 10 bits when the cursor sits above the display start
   assign cursor_vstart = vcsr - vdsr;
   assign cursor_vend   = vcer - vdsr;

endmodule

`default_nettype wire

// ==== rtl/dma_tracker.sv ====
/*
 * Follows video and cursor DMA bursts from the request and acknowledge
 * strobes. Gives one load pulse per beat and counts bursts per frame,
 * latching the counts and stepping the frame counter at flyback.
 */

`timescale 1ns/1ps
`default_nettype none

module dma_tracker import vidc_pkg::*; (
   input  wire           clk,
   input  wire           reset,
   input  wire           hs,
   input  wire           vdrq_n,
   input  wire           vdak_rise,
   input  wire           flybk_start,
   output logic          load_dma,
   output logic          load_dma_cursor,
   output dma_count_t    video_dma_count,
   output dma_count_t    cursor_dma_count,
   output frame_count_t  fr_count
);

   localparam int BEAT_W = $clog2(DMA_BEATS);

   dma_state_e          state;
   logic [BEAT_W-1:0]   beats_left;
   dma_count_t          int_v_count;
   dma_count_t          int_c_count;
   logic                video_start;
   logic                cursor_start;

   // Line sync tells the two request kinds apart
   assign video_start  = (state == dma_idle) && !vdrq_n && hs;
   assign cursor_start = (state == dma_idle) && !vdrq_n && !hs;

   ////////////////////
   // Burst FSM
   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= dma_idle;
         beats_left <= '0;
      end else begin
         case (state)
            dma_idle: begin
               if (video_start) begin
                  state      <= dma_video;
                  beats_left <= BEAT_W'(DMA_BEATS - 1);
               end else if (cursor_start) begin
                  state      <= dma_cursor;
                  beats_left <= BEAT_W'(DMA_BEATS - 1);
               end
            end
            dma_video, dma_cursor: begin
               if (vdak_rise) begin
                  if (beats_left != '0)
                     beats_left <= beats_left - 1'b1;
                  else
                     state <= dma_idle;   // Last beat seen
               end
            end
            default: state <= dma_idle;
         endcase
      end
   end

   // Data is valid on dma_data in the same cycle
   assign load_dma        = (state == dma_video) && vdak_rise;
   assign load_dma_cursor = (state == dma_cursor) && vdak_rise;

   ////////////////////
   // Per-frame counters
   always_ff @(posedge clk) begin
      if (reset) begin
         int_v_count      <= '0;
         int_c_count      <= '0;
         video_dma_count  <= '0;
         cursor_dma_count <= '0;
         fr_count         <= '0;
      end else if (flybk_start) begin
         video_dma_count  <= int_v_count;
         cursor_dma_count <= int_c_count;
         fr_count         <= fr_count + 1'b1;
         // A burst starting right now belongs to the new frame
         int_v_count      <= dma_count_t'(video_start);
         int_c_count      <= dma_count_t'(cursor_start);
      end else begin
         if (video_start)
            int_v_count <= int_v_count + 1'b1;
         if (cursor_start)
            int_c_count <= int_c_count + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/pin_sync.sv ====
/*
 * Input synchronisers for the VIDC pins. Strobes and data run through
 * three-stage histories so that edges can be found and the data word
 * sampled with a strobe can be picked out of the data history.
 */

`timescale 1ns/1ps
`default_nettype none

module pin_sync import vidc_pkg::*; (
   input  wire         clk,
   input  wire         reset,
   input  vidc_word_t  d,
   input  wire         nvidw,
   input  wire         nhs,
   input  wire         flybk,
   input  wire         nvidrq,
   input  wire         nvidak,
   output logic        wr_strobe,
   output vidc_word_t  wr_word,
   output vidc_word_t  dma_word,
   output logic        hs,
   output logic        vdrq_n,
   output logic        flybk_start,
   output logic        vdak_rise
);

   logic [2:0] s_vidw;
   logic [2:0] s_hs;
   logic [2:0] s_flybk;
   logic [2:0] s_vdrq;
   logic [2:0] s_vdak;
   vidc_word_t d_hist [3];

   always_ff @(posedge clk) begin
      if (reset) begin
         s_vidw  <= 3'b111;   // Active low strobes idle high
         s_hs    <= 3'b111;
         s_vdrq  <= 3'b111;
         s_vdak  <= 3'b111;
         s_flybk <= 3'b000;
      end else begin
         s_vidw  <= {s_vidw[1:0], nvidw};
         s_hs    <= {s_hs[1:0], nhs};
         s_flybk <= {s_flybk[1:0], flybk};
         s_vdrq  <= {s_vdrq[1:0], nvidrq};
         s_vdak  <= {s_vdak[1:0], nvidak};
      end
   end

   // Data pipeline keeps pace with the strobe histories
   always_ff @(posedge clk) begin
      d_hist[0] <= d;
      d_hist[1] <= d_hist[0];
      d_hist[2] <= d_hist[1];
   end

   assign wr_strobe   = s_vidw[2] & ~s_vidw[1];   // First low sample
   assign wr_word     = d_hist[1];                // Sampled with that low strobe
   assign dma_word    = d_hist[2];                // Still from the ack-low window
   assign hs          = s_hs[1];
   assign vdrq_n      = s_vdrq[1];
   assign flybk_start = ~s_flybk[2] & s_flybk[1];
   assign vdak_rise   = ~s_vdak[2] & s_vdak[1];

endmodule

`default_nettype wire

// ==== rtl/vidc_capture.sv ====
/*
 * Passive VIDC bus observer, top level. Connects the pin synchronisers,
 * the register mirror, the cursor geometry and the DMA tracker. The
 * controller pins are only sampled, never driven.
 */

`timescale 1ns/1ps
`default_nettype none

module vidc_capture import vidc_pkg::*; (
   input  wire              clk,
   input  wire              reset,
   // Controller pins
   input  vidc_word_t       d,
   input  wire              nvidw,
   input  wire              nhs,
   input  wire              flybk,
   input  wire              nvidrq,
   input  wire              nvidak,
   input  wire              conf_hires,
   // Register readback and mode change
   input  reg_addr_t        rdata_sel,
   output reg_data_t        rdata,
   output logic             tregs_status,
   input  wire              tregs_ack,
   // Display exports
   output palette_t         palette,
   output cursor_palette_t  cursor_palette,
   output cursor_x_t        cursor_hstart,
   output timing_t          cursor_vstart,
   output timing_t          cursor_vend,
   // Frame and DMA info
   output frame_count_t     fr_count,
   output dma_count_t       video_dma_count,
   output dma_count_t       cursor_dma_count,
   output logic             load_dma,
   output logic             load_dma_cursor,
   output vidc_word_t       dma_data
);

   logic          wr_strobe;
   vidc_word_t    wr_word;
   logic          hs;
   logic          vdrq_n;
   logic          flybk_start;
   logic          vdak_rise;
   cursor_hpos_t  hcsr;
   timing_t       vdsr;
   timing_t       vcsr;
   timing_t       vcer;

   pin_sync u_pin_sync (
      .clk         (clk),
      .reset       (reset),
      .d           (d),
      .nvidw       (nvidw),
      .nhs         (nhs),
      .flybk       (flybk),
      .nvidrq      (nvidrq),
      .nvidak      (nvidak),
      .wr_strobe   (wr_strobe),
      .wr_word     (wr_word),
      .dma_word    (dma_data),
      .hs          (hs),
      .vdrq_n      (vdrq_n),
      .flybk_start (flybk_start),
      .vdak_rise   (vdak_rise)
   );

   vidc_regfile u_regfile (
      .clk            (clk),
      .reset          (reset),
      .wr_strobe      (wr_strobe),
      .wr_word        (wr_word),
      .rdata_sel      (rdata_sel),
      .tregs_ack      (tregs_ack),
      .rdata          (rdata),
      .tregs_status   (tregs_status),
      .palette        (palette),
      .cursor_palette (cursor_palette),
      .hcsr           (hcsr),
      .vdsr           (vdsr),
      .vcsr           (vcsr),
      .vcer           (vcer)
   );

   cursor_geometry u_cursor (
      .conf_hires    (conf_hires),
      .hcsr          (hcsr),
      .vdsr          (vdsr),
      .vcsr          (vcsr),
      .vcer          (vcer),
      .cursor_hstart (cursor_hstart),
      .cursor_vstart (cursor_vstart),
      .cursor_vend   (cursor_vend)
   );

   dma_tracker u_dma (
      .clk              (clk),
      .reset            (reset),
      .hs               (hs),
      .vdrq_n           (vdrq_n),
      .vdak_rise        (vdak_rise),
      .flybk_start      (flybk_start),
      .load_dma         (load_dma),
      .load_dma_cursor  (load_dma_cursor),
      .video_dma_count  (video_dma_count),
      .cursor_dma_count (cursor_dma_count),
      .fr_count         (fr_count)
   );

endmodule

`default_nettype wire

// ==== rtl/vidc_pkg.sv ====
/*
 * Shared widths, register addresses and DMA state encoding for the
 * VIDC bus observer. Every RTL block takes these by wildcard import.
 */

`default_nettype none

package vidc_pkg;

   ////////////////////
   // Bus and register widths
   typedef logic [31:0]  vidc_word_t;      // Raw data bus word
   typedef logic [5:0]   reg_addr_t;       // Register number, also readback select
   typedef logic [23:0]  reg_data_t;       // Register payload
   typedef logic [11:0]  colour_t;         // 4:4:4 colour
   typedef logic [9:0]   timing_t;         // Display timing value
   typedef logic [12:0]  cursor_hpos_t;    // HCSR holds extra fine bits
   typedef logic [10:0]  cursor_x_t;

   typedef logic [191:0] palette_t;        // 16 colours, entry 0 lowest
   typedef logic [35:0]  cursor_palette_t; // Cursor colours 3,2,1

   typedef logic [15:0]  dma_count_t;
   typedef logic [3:0]   frame_count_t;

   // Words per DMA burst
   localparam int DMA_BEATS = 4;

   ////////////////////
   // Register addresses (bus address / 4)
   localparam reg_addr_t ADDR_BORDER      = 6'h10;
   localparam reg_addr_t ADDR_CURSOR_COL1 = 6'h11;
   localparam reg_addr_t ADDR_HCR         = 6'h20;
   localparam reg_addr_t ADDR_HCSR        = 6'h26;
   localparam reg_addr_t ADDR_VCR         = 6'h28;
   localparam reg_addr_t ADDR_VDSR        = 6'h2B;
   localparam reg_addr_t ADDR_VCSR        = 6'h2E;
   localparam reg_addr_t ADDR_VCER        = 6'h2F;

   // Field positions within the payload
   localparam int TIMING_LSB = 14;
   localparam int HCSR_LSB   = 11;

   // Burst tracker states
   typedef enum logic [1:0] {
      dma_idle,
      dma_video,
      dma_cursor
   } dma_state_e;

endpackage

`default_nettype wire

// ==== rtl/vidc_regfile.sv ====
/*
 * Mirror of the VIDC colour and display timing registers. Writes seen
 * on the bus update the mirrors, a select reads any of them back, and
 * writes to HCR or VCR flip a mode-change toggle for the display side.
 */

`timescale 1ns/1ps
`default_nettype none

module vidc_regfile import vidc_pkg::*; (
   input  wire              clk,
   input  wire              reset,
   input  wire              wr_strobe,
   input  vidc_word_t       wr_word,
   input  reg_addr_t        rdata_sel,
   input  wire              tregs_ack,
   output reg_data_t        rdata,
   output logic             tregs_status,
   output palette_t         palette,
   output cursor_palette_t  cursor_palette,
   output cursor_hpos_t     hcsr,
   output timing_t          vdsr,
   output timing_t          vcsr,
   output timing_t          vcer
);

   reg_addr_t    wr_addr;
   reg_data_t    wr_data;
   logic         is_palette;
   logic         is_cursor_col;
   logic         is_timing;
   logic         tregs_hit;

   colour_t      vplc [16];       // Video palette
   colour_t      border;
   colour_t      cplc [1:3];      // Cursor colours 1 to 3
   timing_t      timing_r [16];   // 0x20..0x2F, HCSR slot held apart
   cursor_hpos_t hcsr_r;

   ////////////////////
   // Write decode
   assign wr_addr = wr_word[31:26];
   assign wr_data = wr_word[23:0];

   assign is_palette    = (wr_addr[5:4] == 2'b00);
   assign is_cursor_col = (wr_addr[5:2] == ADDR_CURSOR_COL1[5:2]) &&
                          (wr_addr[1:0] != 2'b00);
   assign is_timing     = (wr_addr[5:4] == ADDR_HCR[5:4]);

   // Only HCR and VCR count as a mode change
   assign tregs_hit = (wr_addr == ADDR_HCR) || (wr_addr == ADDR_VCR);

   always_ff @(posedge clk) begin
      if (wr_strobe) begin
         if (is_palette) begin
            vplc[wr_addr[3:0]] <= wr_data[11:0];
         end else if (wr_addr == ADDR_BORDER) begin
            border <= wr_data[11:0];
         end else if (is_cursor_col) begin
            cplc[wr_addr[1:0]] <= wr_data[11:0];
         end else if (is_timing) begin
            if (wr_addr == ADDR_HCSR)
               hcsr_r <= wr_data[23:HCSR_LSB];     // Keeps the fine position bits
            else
               timing_r[wr_addr[3:0]] <= wr_data[23:TIMING_LSB];
         end
      end
   end

   ////////////////////
   // Mode-change toggle
   always_ff @(posedge clk) begin
      if (reset) begin
         tregs_status <= 1'b0;
      end else if (wr_strobe && tregs_hit && (tregs_ack == tregs_status)) begin
         tregs_status <= ~tregs_status;   // Held until the consumer catches up
      end
   end

   ////////////////////
   // Readback
   always_comb begin
      rdata = '0;
      if (rdata_sel[5:4] == 2'b00) begin
         rdata = reg_data_t'(vplc[rdata_sel[3:0]]);
      end else if (rdata_sel == ADDR_BORDER) begin
         rdata = reg_data_t'(border);
      end else if ((rdata_sel[5:2] == ADDR_CURSOR_COL1[5:2]) &&
                   (rdata_sel[1:0] != 2'b00)) begin
         rdata = reg_data_t'(cplc[rdata_sel[1:0]]);
      end else if (rdata_sel[5:4] == ADDR_HCR[5:4]) begin
         if (rdata_sel == ADDR_HCSR)
            rdata = reg_data_t'(hcsr_r) << HCSR_LSB;
         else
            rdata = reg_data_t'(timing_r[rdata_sel[3:0]]) << TIMING_LSB;
      end
   end

   ////////////////////
   // Exports to the display side
   always_comb begin
      for (int i = 0; i < 16; i++) begin
         palette[i*12 +: 12] = vplc[i];
      end
   end

   assign cursor_palette = {cplc[3], cplc[2], cplc[1]};

   assign hcsr = hcsr_r;
   assign vdsr = timing_r[ADDR_VDSR[3:0]];
   assign vcsr = timing_r[ADDR_VCSR[3:0]];
   assign vcer = timing_r[ADDR_VCER[3:0]];

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/vidc_pkg.sv
rtl/pin_sync.sv
rtl/vidc_regfile.sv
rtl/cursor_geometry.sv
rtl/dma_tracker.sv
rtl/vidc_capture.sv
test/tb_vidc_capture.sv

// ==== test/tb_vidc_capture.sv ====
/*
 * Self-checking testbench for the VIDC bus observer. Reads one command
 * per line from test/vidc_cases.txt, drives it on the controller pins
 * and compares the observer's outputs with the expected values given.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_vidc_capture import vidc_pkg::*; ();

   logic             clk;
   logic             reset;
   vidc_word_t       d;
   logic             nvidw, nhs, flybk, nvidrq, nvidak, conf_hires;
   reg_addr_t        rdata_sel;
   reg_data_t        rdata;
   logic             tregs_status, tregs_ack;
   palette_t         palette;
   cursor_palette_t  cursor_palette;
   cursor_x_t        cursor_hstart;
   timing_t          cursor_vstart, cursor_vend;
   frame_count_t     fr_count;
   dma_count_t       video_dma_count, cursor_dma_count;
   logic             load_dma, load_dma_cursor;
   vidc_word_t       dma_data;

   int               errors;
   int               tests;
   logic [31:0]      lfsr = 32'h873d;
   vidc_word_t       video_beats [$];   // dma_data seen on each strobe
   vidc_word_t       cursor_beats [$];

   vidc_capture uut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Strobes are combinational off registers, so look between edges
   always @(negedge clk) begin
      if (!reset) begin
         if (load_dma) video_beats.push_back(dma_data);
         if (load_dma_cursor) cursor_beats.push_back(dma_data);
      end
   end

   ////////////////////
   // Compare tasks
   task automatic report_mismatch(input string name, input logic [191:0] got,
                                  input logic [191:0] exp);
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) report_mismatch(name, 192'(got), 192'(exp));
   endtask

   task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
      if (got !== exp) report_mismatch(name, 192'(got), 192'(exp));
   endtask

   task automatic check_timing(input string name, input timing_t got, input timing_t exp);
      if (got !== exp) report_mismatch(name, 192'(got), 192'(exp));
   endtask

   task automatic check_x(input string name, input cursor_x_t got, input cursor_x_t exp);
      if (got !== exp) report_mismatch(name, 192'(got), 192'(exp));
   endtask

   task automatic check_count(input string name, input dma_count_t got, input dma_count_t exp);
      if (got !== exp) report_mismatch(name, 192'(got), 192'(exp));
   endtask

   task automatic check_frames(input string name, input frame_count_t got,
                               input frame_count_t exp);
      if (got !== exp) report_mismatch(name, 192'(got), 192'(exp));
   endtask

   task automatic check_word(input string name, input vidc_word_t got, input vidc_word_t exp);
      if (got !== exp) report_mismatch(name, 192'(got), 192'(exp));
   endtask

   task automatic check_palette(input string name, input palette_t got, input palette_t exp);
      if (got !== exp) report_mismatch(name, got, exp);
   endtask

   task automatic check_cursor_palette(input string name, input cursor_palette_t got,
                                       input cursor_palette_t exp);
      if (got !== exp) report_mismatch(name, 192'(got), 192'(exp));
   endtask

   ////////////////////
   // Pin drivers
   task automatic next_cycle;
      @(posedge clk);
      #1;
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic idle_gap;
      int gap;
      gap = 0;
      for (int i = 0; i < 3; i++) begin
         lfsr = lfsr_next(lfsr);
         gap = gap * 2 + int'(lfsr[0]);
      end
      repeat (gap + 2) next_cycle();   // 2 to 9 cycles
   endtask

   task automatic do_write(input reg_addr_t addr, input reg_data_t data);
      d = {addr, 2'b00, data};
      repeat (2) next_cycle();           // Data settles before the strobe
      nvidw = 1'b0;
      repeat (4) next_cycle();
      nvidw = 1'b1;
      repeat (4) next_cycle();
   endtask

   task automatic do_read(input reg_addr_t sel, input reg_data_t exp);
      palette_t        mask;
      palette_t        want;
      cursor_palette_t cmask;
      cursor_palette_t cwant;
      rdata_sel = sel;
      @(negedge clk);
      check_data("rdata", rdata, exp);
      if (sel[5:4] == 2'b00) begin
         // Other entries may still be unwritten
         mask = palette_t'(12'hfff) << (12 * sel[3:0]);
         want = palette_t'(exp[11:0]) << (12 * sel[3:0]);
         check_palette("palette", palette & mask, want);
      end else if (sel >= ADDR_CURSOR_COL1 && sel <= ADDR_CURSOR_COL1 + 6'd2) begin
         // Cursor colour 1 sits in the lowest slice
         cmask = cursor_palette_t'(12'hfff) << (12 * (sel - ADDR_CURSOR_COL1));
         cwant = cursor_palette_t'(exp[11:0]) << (12 * (sel - ADDR_CURSOR_COL1));
         check_cursor_palette("cursor_palette", cursor_palette & cmask, cwant);
      end
      next_cycle();
   endtask

   task automatic do_cursor(input logic hires, input cursor_x_t h, input timing_t vs,
                            input timing_t ve);
      conf_hires = hires;
      @(negedge clk);
      check_x("cursor_hstart", cursor_hstart, h);
      check_timing("cursor_vstart", cursor_vstart, vs);
      check_timing("cursor_vend", cursor_vend, ve);
      next_cycle();
   endtask

   // Checks the toggle, then acknowledges it
   task automatic do_toggle(input logic exp);
      @(negedge clk);
      check_flag("tregs_status", tregs_status, exp);
      next_cycle();
      tregs_ack = tregs_status;
   endtask

   task automatic do_burst(input logic video, input vidc_word_t words[4]);
      vidc_word_t mine [$];
      int         other_n;
      int         cycles;
      video_beats.delete();
      cursor_beats.delete();
      nhs    = video;                    // Line sync high marks video DMA
      nvidrq = 1'b0;
      repeat (2) next_cycle();
      for (int i = 0; i < DMA_BEATS; i++) begin
         d      = words[i];
         nvidak = 1'b0;
         repeat (3) next_cycle();
         nvidak = 1'b1;
         nvidrq = 1'b1;
         repeat (3) next_cycle();
      end
      cycles = 0;
      while (video_beats.size() + cursor_beats.size() < DMA_BEATS && cycles < 40) begin
         next_cycle();
         cycles++;
      end
      if (cycles >= 40) begin
         $display("Timeout waiting for the DMA beat strobes");
         errors++;
      end
      repeat (4) next_cycle();           // Room for any stray strobe
      if (video) begin
         mine    = video_beats;
         other_n = cursor_beats.size();
      end else begin
         mine    = cursor_beats;
         other_n = video_beats.size();
      end
      if (mine.size() != DMA_BEATS) begin
         $display("Burst gave %0d beat strobes instead of %0d", mine.size(), DMA_BEATS);
         errors++;
      end
      if (other_n != 0) begin
         $display("Burst pulsed the load strobe of the other DMA kind %0d times", other_n);
         errors++;
      end
      for (int i = 0; i < mine.size() && i < DMA_BEATS; i++)
         check_word("dma_data", mine[i], words[i]);
      nhs = 1'b1;
   endtask

   task automatic do_frame(input dma_count_t ev, input dma_count_t ec, input frame_count_t ef);
      frame_count_t old;
      int           cycles;
      old    = fr_count;
      flybk  = 1'b1;
      cycles = 0;
      while (fr_count == old && cycles < 20) begin
         next_cycle();
         cycles++;
      end
      if (cycles >= 20) begin
         $display("Timeout waiting for the frame counter to step");
         errors++;
      end
      check_count("video_dma_count", video_dma_count, ev);
      check_count("cursor_dma_count", cursor_dma_count, ec);
      check_frames("fr_count", fr_count, ef);
      repeat (2) next_cycle();
      flybk = 1'b0;
   endtask

   ////////////////////
   // Main sequence
   initial begin
      int              fd;
      int              n;
      int              errs_before;
      string           line;
      string           cmd;
      string           kind;
      logic [31:0]     a, b, c, e;
      vidc_word_t      w [4];

      reset = 1'b1;
      d = '0;
      nvidw = 1'b1;
      nhs = 1'b1;
      flybk = 1'b0;
      nvidrq = 1'b1;
      nvidak = 1'b1;
      conf_hires = 1'b0;
      rdata_sel = '0;
      tregs_ack = 1'b0;
      errors = 0;
      tests = 0;
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;

      @(negedge clk);
      check_flag("tregs_status", tregs_status, 1'b0);
      check_flag("load_dma", load_dma, 1'b0);
      check_flag("load_dma_cursor", load_dma_cursor, 1'b0);
      check_frames("fr_count", fr_count, '0);
      check_count("video_dma_count", video_dma_count, '0);
      check_count("cursor_dma_count", cursor_dma_count, '0);
      tests++;
      $display("test %0d reset: %s", tests, errors == 0 ? "ok" : "FAILED");
      next_cycle();

      fd = $fopen("test/vidc_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open the case file test/vidc_cases.txt");
         errors++;
      end else begin
         line = "";
         while ($fgets(line, fd) != 0) begin
            cmd = "";
            n = $sscanf(line, "%s", cmd);
            if (n == 1 && cmd != "#") begin
               errs_before = errors;
               if (cmd == "write") begin
                  n = $sscanf(line, "%s %h %h", cmd, a, b);
                  do_write(a[5:0], b[23:0]);
               end else if (cmd == "read") begin
                  n = $sscanf(line, "%s %h %h", cmd, a, b);
                  do_read(a[5:0], b[23:0]);
               end else if (cmd == "cursor") begin
                  n = $sscanf(line, "%s %h %h %h %h", cmd, a, b, c, e);
                  do_cursor(a[0], b[10:0], c[9:0], e[9:0]);
               end else if (cmd == "toggle") begin
                  n = $sscanf(line, "%s %h", cmd, a);
                  do_toggle(a[0]);
               end else if (cmd == "burst") begin
                  n = $sscanf(line, "%s %s %h %h %h %h", cmd, kind, w[0], w[1], w[2], w[3]);
                  do_burst(kind == "v", w);
               end else if (cmd == "frame") begin
                  n = $sscanf(line, "%s %h %h %h", cmd, a, b, c);
                  do_frame(a[15:0], b[15:0], c[3:0]);
               end else begin
                  $display("Unknown command %s in the case file", cmd);
                  errors++;
               end
               tests++;
               $display("test %0d %s: %s", tests, cmd, errors == errs_before ? "ok" : "FAILED");
               idle_gap();
            end
            line = "";
         end
         $fclose(fd);
      end

      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/vidc_cases.txt ====
# One command per line, operands in hex
# write addr payload | read sel expected | cursor hires h vstart vend | toggle status
# burst v|c word0 word1 word2 word3 | frame video_count cursor_count frames
write 00 000123
write 0f 000fed
write 05 abc789
write 10 000a5a
write 11 000111
write 13 000333
read 00 000123
read 0f 000fed
read 05 000789
read 10 000a5a
read 11 000111
read 13 000333
write 21 fedcba
read 21 fec000
read 14 000000
read 3f 000000
write 26 d5e000
write 2b 100000
write 2e 400000
write 2f 480000
read 26 d5e000
read 2b 100000
cursor 0 6af 0c0 0e0
cursor 1 2bc 0c0 0e0
write 2e 080000
read 2e 080000
cursor 1 2bc 3e0 0e0
# toggle checks tregs_status, then copies it onto tregs_ack
toggle 0
write 20 123456
write 20 654321
toggle 1
write 28 0abcde
toggle 0
write 2a 111111
toggle 0
burst v 11111111 22222222 33333333 44444444
burst c a0a0a0a0 b1b1b1b1 c2c2c2c2 d3d3d3d3
frame 1 1 1
burst v 01234567 89abcdef fedcba98 76543210
burst v deadbeef 00000000 ffffffff 5a5a5a5a
burst c 0000000c 000000c0 00000c00 0000c000
burst v 13579bdf 2468ace0 0f0f0f0f f0f0f0f0
frame 3 1 2
frame 0 0 3
